// ==== snake_game_pkg.sv ====
package snake_game_pkg;

	//////////////////////////////
	// playfield geometry
	//////////////////////////////
	typedef logic [5:0] coord_t; // cell coordinate

	localparam coord_t GRID_MIN = 6'd1; // first playable cell
	localparam coord_t GRID_MAX = 6'd13; // last playable cell
	localparam coord_t WALL_LO = 6'd0;
	localparam coord_t WALL_HI = 6'd14;

	localparam int CELL_SHIFT = 5; // 32 pixel cells

	// movement direction with bit 1 set for vertical
	typedef enum logic [1:0] {
		DIR_RIGHT = 2'b00,
		DIR_LEFT  = 2'b01,
		DIR_UP    = 2'b10,
		DIR_DOWN  = 2'b11
	} dir_t;

	//////////////////////////////
	// snake body and score
	//////////////////////////////
	localparam int MAX_LEN = 16; // head included
	localparam int SEG_IDX_W = $clog2(MAX_LEN);

	typedef logic [SEG_IDX_W-1:0] seg_idx_t;
	typedef logic [4:0] len_t;
	typedef logic [11:0] score_t;

	localparam coord_t HEAD_START_X = 6'd2;
	localparam coord_t HEAD_START_Y = 6'd12;

	// apple start cell and placement sequence
	localparam coord_t APPLE_START_X = 6'd10;
	localparam coord_t APPLE_START_Y = 6'd10;

	typedef logic [15:0] lfsr_t;

	localparam lfsr_t APPLE_SEED = 16'hACE1;
	localparam lfsr_t APPLE_TAPS = 16'hB400; // taps 16 14 13 11

	//////////////////////////////
	// colours
	//////////////////////////////
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	localparam rgb_t COLOR_WALL = '{r: 8'hB0, g: 8'h40, b: 8'h20}; // brick
	localparam rgb_t COLOR_HEAD = '{r: 8'h20, g: 8'hE0, b: 8'h20};
	localparam rgb_t COLOR_HEAD_BITTEN = '{r: 8'hE0, g: 8'h20, b: 8'hE0};
	localparam rgb_t COLOR_BODY = '{r: 8'h10, g: 8'h90, b: 8'h10};
	localparam rgb_t COLOR_APPLE = '{r: 8'hF0, g: 8'h10, b: 8'h10};
	localparam rgb_t COLOR_BACKGROUND = '{r: 8'h00, g: 8'h00, b: 8'h00};

endpackage

// ==== snake_apb_pkg.sv ====
package snake_apb_pkg;

	localparam int APB_ADDR_W = 8;
	localparam int APB_DATA_W = 32;

	// register map
	localparam logic [APB_ADDR_W-1:0] REG_CTRL = 8'h00;
	localparam logic [APB_ADDR_W-1:0] REG_PERIOD = 8'h04;
	localparam logic [APB_ADDR_W-1:0] REG_SCORE = 8'h08; // read only
	localparam logic [APB_ADDR_W-1:0] REG_STATUS = 8'h0C; // read only

	// field positions
	localparam int CTRL_RUN_BIT = 0;
	localparam int STATUS_BITTEN_BIT = 0;
	localparam int STATUS_LEN_LSB = 8;

	// move interval in clocks
	localparam int PERIOD_W = 25;

	typedef logic [PERIOD_W-1:0] period_t;

	localparam period_t PERIOD_RESET = 25'd25000000;
	localparam period_t MIN_PERIOD = 25'd24; // longer than a full bite scan

endpackage

// ==== snake_state_if.sv ====
`timescale 1ns/1ps

interface snake_state_if;

	snake_game_pkg::coord_t seg_x [snake_game_pkg::MAX_LEN]; // index 0 is the head
	snake_game_pkg::coord_t seg_y [snake_game_pkg::MAX_LEN];
	snake_game_pkg::len_t   len;
	snake_game_pkg::score_t score;
	snake_game_pkg::coord_t apple_x;
	snake_game_pkg::coord_t apple_y;
	logic                   bitten;

	// movement owns the body, reads the apple for meals
	modport motion_mp (output seg_x, seg_y, len, score, input apple_x, apple_y);

	modport apple_mp (output apple_x, apple_y);

	modport bite_mp (input seg_x, seg_y, len, output bitten);

	// renderer and register block
	modport view_mp (input seg_x, seg_y, len, score, apple_x, apple_y, bitten);

endinterface

// ==== snake_apb_regs.sv ====
`timescale 1ns/1ps

module snake_apb_regs (
	input  logic                                 i_clk_74M,
	input  logic                                 i_reset,
	input  logic                                 i_psel,
	input  logic                                 i_penable,
	input  logic                                 i_pwrite,
	input  logic [snake_apb_pkg::APB_ADDR_W-1:0] i_paddr,
	input  logic [snake_apb_pkg::APB_DATA_W-1:0] i_pwdata,
	output logic [snake_apb_pkg::APB_DATA_W-1:0] o_prdata,
	output logic                                 o_pready,
	output logic                                 o_pslverr,
	snake_state_if.view_mp                       state,
	output logic                                 o_run,
	output snake_apb_pkg::period_t               o_period
);

	logic                   access;
	logic                   addr_rw;
	logic                   addr_ro;
	logic                   wr_en;
	snake_apb_pkg::period_t wr_period;

	assign access = i_psel & i_penable; // access phase
	assign addr_rw = (i_paddr == snake_apb_pkg::REG_CTRL) || (i_paddr == snake_apb_pkg::REG_PERIOD);
	assign addr_ro = (i_paddr == snake_apb_pkg::REG_SCORE) || (i_paddr == snake_apb_pkg::REG_STATUS);
	assign wr_en = access & i_pwrite & addr_rw;

	assign o_pready = 1'b1; // zero wait states
	assign o_pslverr = access & (i_pwrite ? !addr_rw : !(addr_rw | addr_ro));

	// short intervals get raised to the floor
	assign wr_period = (i_pwdata[snake_apb_pkg::PERIOD_W-1:0] < snake_apb_pkg::MIN_PERIOD) ?
		snake_apb_pkg::MIN_PERIOD : i_pwdata[snake_apb_pkg::PERIOD_W-1:0];

	always_ff @(posedge i_clk_74M) begin
		if (i_reset) begin
			o_run <= 1'b0;
			o_period <= snake_apb_pkg::PERIOD_RESET;
		end else if (wr_en) begin
			if (i_paddr == snake_apb_pkg::REG_CTRL) begin
				o_run <= i_pwdata[snake_apb_pkg::CTRL_RUN_BIT];
			end else begin
				o_period <= wr_period;
			end
		end
	end

	// read data valid in the access cycle
	always_comb begin
		o_prdata = '0;
		case (i_paddr)
			snake_apb_pkg::REG_CTRL: o_prdata[snake_apb_pkg::CTRL_RUN_BIT] = o_run;
			snake_apb_pkg::REG_PERIOD: o_prdata[snake_apb_pkg::PERIOD_W-1:0] = o_period;
			snake_apb_pkg::REG_SCORE: o_prdata[$bits(snake_game_pkg::score_t)-1:0] = state.score;
			snake_apb_pkg::REG_STATUS: begin
				o_prdata[snake_apb_pkg::STATUS_BITTEN_BIT] = state.bitten;
				o_prdata[snake_apb_pkg::STATUS_LEN_LSB +: $bits(snake_game_pkg::len_t)] =
					state.len;
			end
			default: o_prdata = '0; // unmapped
		endcase
	end

endmodule

// ==== snake_motion.sv ====
`timescale 1ns/1ps

module snake_motion (
	input  logic                   i_clk_74M,
	input  logic                   i_reset,
	input  logic                   i_run,
	input  snake_apb_pkg::period_t i_period,
	input  logic                   i_btn_right,
	input  logic                   i_btn_left,
	input  logic                   i_btn_up,
	input  logic                   i_btn_down,
	snake_state_if.motion_mp       state,
	output logic                   o_step,
	output logic                   o_eat
);

	snake_game_pkg::dir_t   dir;
	snake_apb_pkg::period_t cnt;
	logic                   run_q;
	snake_game_pkg::coord_t next_x;
	snake_game_pkg::coord_t next_y;

	//////////////////////////////
	// steering
	//////////////////////////////
	always_ff @(posedge i_clk_74M) begin
		if (i_reset) begin
			dir <= snake_game_pkg::DIR_RIGHT;
		end else if (i_btn_right && dir[1]) begin // only from a vertical move
			dir <= snake_game_pkg::DIR_RIGHT;
		end else if (i_btn_left && dir[1]) begin
			dir <= snake_game_pkg::DIR_LEFT;
		end else if (i_btn_down && !dir[1]) begin // only from a horizontal move
			dir <= snake_game_pkg::DIR_DOWN;
		end else if (i_btn_up && !dir[1]) begin
			dir <= snake_game_pkg::DIR_UP;
		end
	end

	//////////////////////////////
	// move interval
	//////////////////////////////
	always_ff @(posedge i_clk_74M) begin
		if (i_reset) begin
			run_q <= 1'b0;
			cnt <= snake_apb_pkg::period_t'(1);
		end else begin
			run_q <= i_run;
			if ((i_run && !run_q) || o_step) begin
				cnt <= snake_apb_pkg::period_t'(1); // fresh interval
			end else if (i_run) begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	assign o_step = i_run & run_q & (cnt >= i_period);

	// next head cell with wrap at the field edge
	always_comb begin
		next_x = state.seg_x[0];
		next_y = state.seg_y[0];
		case (dir)
			snake_game_pkg::DIR_RIGHT: begin
				if (state.seg_x[0] >= snake_game_pkg::GRID_MAX) next_x = snake_game_pkg::GRID_MIN;
				else next_x = state.seg_x[0] + 1'b1;
			end
			snake_game_pkg::DIR_LEFT: begin
				if (state.seg_x[0] <= snake_game_pkg::GRID_MIN) next_x = snake_game_pkg::GRID_MAX;
				else next_x = state.seg_x[0] - 1'b1;
			end
			snake_game_pkg::DIR_DOWN: begin
				if (state.seg_y[0] >= snake_game_pkg::GRID_MAX) next_y = snake_game_pkg::GRID_MIN;
				else next_y = state.seg_y[0] + 1'b1;
			end
			default: begin // up
				if (state.seg_y[0] <= snake_game_pkg::GRID_MIN) next_y = snake_game_pkg::GRID_MAX;
				else next_y = state.seg_y[0] - 1'b1;
			end
		endcase
	end

	assign o_eat = o_step && (next_x == state.apple_x) && (next_y == state.apple_y);

	//////////////////////////////
	// head, length and score
	//////////////////////////////
	always_ff @(posedge i_clk_74M) begin
		if (i_reset) begin
			state.seg_x[0] <= snake_game_pkg::HEAD_START_X;
			state.seg_y[0] <= snake_game_pkg::HEAD_START_Y;
			state.len <= snake_game_pkg::len_t'(1);
			state.score <= '0;
		end else if (o_step) begin
			state.seg_x[0] <= next_x;
			state.seg_y[0] <= next_y;
			if (o_eat) begin
				state.score <= state.score + 1'b1;
				if (state.len < snake_game_pkg::MAX_LEN) state.len <= state.len + 1'b1;
			end
		end
	end

	// each segment takes the place of the one ahead
	for (genvar i = 1; i < snake_game_pkg::MAX_LEN; i++) begin : g_body
		always_ff @(posedge i_clk_74M) begin
			if (o_step) begin
				state.seg_x[i] <= state.seg_x[i-1];
				state.seg_y[i] <= state.seg_y[i-1];
			end
		end
	end

endmodule

// ==== snake_bite_check.sv ====
`timescale 1ns/1ps

module snake_bite_check (
	input  logic           i_clk_74M,
	input  logic           i_reset,
	input  logic           i_step,
	snake_state_if.bite_mp state
);

	snake_game_pkg::seg_idx_t idx; // segment under test
	logic                     busy;
	logic                     hit;

	assign hit = (idx < state.len) &&
		(state.seg_x[idx] == state.seg_x[0]) && (state.seg_y[idx] == state.seg_y[0]);

	// one segment per clock and done long before the next move
	always_ff @(posedge i_clk_74M) begin
		if (i_reset) begin
			busy <= 1'b0;
			idx <= snake_game_pkg::seg_idx_t'(1);
			state.bitten <= 1'b0;
		end else if (i_step) begin
			busy <= 1'b1;
			idx <= snake_game_pkg::seg_idx_t'(1); // skip the head itself
			state.bitten <= 1'b0;
		end else if (busy) begin
			if (hit) begin
				state.bitten <= 1'b1; // sticks until next move
			end
			if (idx == snake_game_pkg::seg_idx_t'(snake_game_pkg::MAX_LEN - 1)) begin
				busy <= 1'b0;
			end else begin
				idx <= idx + 1'b1;
			end
		end
	end

endmodule

// ==== apple_placer.sv ====
`timescale 1ns/1ps

module apple_placer (
	input  logic            i_clk_74M,
	input  logic            i_reset,
	input  logic            i_eat,
	snake_state_if.apple_mp state
);

	snake_game_pkg::lfsr_t lfsr;
	snake_game_pkg::lfsr_t lfsr_next;

	// 4 bit field value onto 1..13 with the top three folding back to 1..3
	function automatic snake_game_pkg::coord_t map_cell(input logic [3:0] v);
		snake_game_pkg::coord_t c;
		c = snake_game_pkg::coord_t'(v);
		if (c <= snake_game_pkg::GRID_MAX - snake_game_pkg::GRID_MIN) begin
			return c + snake_game_pkg::GRID_MIN;
		end else begin
			return c - (snake_game_pkg::GRID_MAX - snake_game_pkg::GRID_MIN);
		end
	endfunction

	assign lfsr_next = {lfsr[14:0], ^(lfsr & snake_game_pkg::APPLE_TAPS)}; // fibonacci step

	always_ff @(posedge i_clk_74M) begin
		if (i_reset) begin
			lfsr <= snake_game_pkg::APPLE_SEED;
			state.apple_x <= snake_game_pkg::APPLE_START_X;
			state.apple_y <= snake_game_pkg::APPLE_START_Y;
		end else if (i_eat) begin
			lfsr <= lfsr_next;
			state.apple_x <= map_cell(lfsr_next[3:0]);
			state.apple_y <= map_cell(lfsr_next[7:4]);
		end
	end

endmodule

// ==== snake_renderer.sv ====
`timescale 1ns/1ps

module snake_renderer (
	input  logic                  i_clk_74M,
	input  logic                  i_reset,
	input  logic [11:0]           i_hcnt,
	input  logic [11:0]           i_vcnt,
	snake_state_if.view_mp        state,
	output snake_game_pkg::rgb_t  o_rgb
);

	logic [11:0]          cell_x;
	logic [11:0]          cell_y;
	logic                 in_area;
	logic                 on_wall;
	logic                 on_head;
	logic                 on_body;
	logic                 on_apple;
	snake_game_pkg::rgb_t pix;

	assign cell_x = i_hcnt >> snake_game_pkg::CELL_SHIFT;
	assign cell_y = i_vcnt >> snake_game_pkg::CELL_SHIFT;

	//////////////////////////////
	// object hits for this cell
	//////////////////////////////
	assign in_area = (cell_x <= 12'(snake_game_pkg::WALL_HI)) &&
		(cell_y <= 12'(snake_game_pkg::WALL_HI)); // 15 by 15 incl border
	assign on_wall = in_area &&
		(cell_x == 12'(snake_game_pkg::WALL_LO) || cell_x == 12'(snake_game_pkg::WALL_HI) ||
		cell_y == 12'(snake_game_pkg::WALL_LO) || cell_y == 12'(snake_game_pkg::WALL_HI));
	assign on_head = (cell_x == 12'(state.seg_x[0])) && (cell_y == 12'(state.seg_y[0]));
	assign on_apple = (cell_x == 12'(state.apple_x)) && (cell_y == 12'(state.apple_y));

	always_comb begin
		on_body = 1'b0;
		for (int i = 1; i < snake_game_pkg::MAX_LEN; i++) begin
			if (i < int'(state.len) && cell_x == 12'(state.seg_x[i]) &&
				cell_y == 12'(state.seg_y[i])) begin
				on_body = 1'b1; // only live segments
			end
		end
	end

	// wall beats head beats body beats apple
	always_comb begin
		if (on_wall) pix = snake_game_pkg::COLOR_WALL;
		else if (on_head) pix = state.bitten ? snake_game_pkg::COLOR_HEAD_BITTEN :
			snake_game_pkg::COLOR_HEAD;
		else if (on_body) pix = snake_game_pkg::COLOR_BODY;
		else if (on_apple) pix = snake_game_pkg::COLOR_APPLE;
		else pix = snake_game_pkg::COLOR_BACKGROUND;
	end

	always_ff @(posedge i_clk_74M) begin
		if (i_reset) o_rgb <= snake_game_pkg::COLOR_BACKGROUND;
		else o_rgb <= pix;
	end

endmodule

// ==== snake_top.sv ====
`timescale 1ns/1ps

module snake_top (
	input  logic                                 i_clk_74M,
	input  logic                                 i_reset,
	input  logic [11:0]                          i_hcnt,
	input  logic [11:0]                          i_vcnt,
	input  logic                                 i_btn_right,
	input  logic                                 i_btn_left,
	input  logic                                 i_btn_up,
	input  logic                                 i_btn_down,
	input  logic                                 i_psel,
	input  logic                                 i_penable,
	input  logic                                 i_pwrite,
	input  logic [snake_apb_pkg::APB_ADDR_W-1:0] i_paddr,
	input  logic [snake_apb_pkg::APB_DATA_W-1:0] i_pwdata,
	output logic [snake_apb_pkg::APB_DATA_W-1:0] o_prdata,
	output logic                                 o_pready,
	output logic                                 o_pslverr,
	output logic [7:0]                           o_r,
	output logic [7:0]                           o_g,
	output logic [7:0]                           o_b
);

	logic                   run;
	snake_apb_pkg::period_t period;
	logic                   step;
	logic                   eat;
	snake_game_pkg::rgb_t   rgb;

	snake_state_if u_state ();

	snake_apb_regs u_regs (
		.i_clk_74M (i_clk_74M), .i_reset (i_reset),
		.i_psel (i_psel), .i_penable (i_penable), .i_pwrite (i_pwrite),
		.i_paddr (i_paddr), .i_pwdata (i_pwdata),
		.o_prdata (o_prdata), .o_pready (o_pready), .o_pslverr (o_pslverr),
		.state (u_state), .o_run (run), .o_period (period)
	);

	snake_motion u_motion (
		.i_clk_74M (i_clk_74M), .i_reset (i_reset), .i_run (run), .i_period (period),
		.i_btn_right (i_btn_right), .i_btn_left (i_btn_left),
		.i_btn_up (i_btn_up), .i_btn_down (i_btn_down),
		.state (u_state), .o_step (step), .o_eat (eat)
	);

	snake_bite_check u_bite (
		.i_clk_74M (i_clk_74M), .i_reset (i_reset), .i_step (step), .state (u_state)
	);

	apple_placer u_apple (
		.i_clk_74M (i_clk_74M), .i_reset (i_reset), .i_eat (eat), .state (u_state)
	);

	snake_renderer u_render (
		.i_clk_74M (i_clk_74M), .i_reset (i_reset), .i_hcnt (i_hcnt), .i_vcnt (i_vcnt),
		.state (u_state), .o_rgb (rgb)
	);

	// split the pixel into the video channels
	assign o_r = rgb.r;
	assign o_g = rgb.g;
	assign o_b = rgb.b;

endmodule

// ==== tb_snake.sv ====
`timescale 1ns/1ps

module tb_snake;

	localparam int clk_half_ns = 4; // 8 ns clock
	localparam int reset_cycles = 5;
	localparam int seed_start = 61057;
	localparam int cmd_clks = 10; // one short command plus idle sweep rounded up
	localparam int slack_clks = 200;

	logic        i_clk_74M;
	logic        i_reset;
	logic [11:0] i_hcnt;
	logic [11:0] i_vcnt;
	logic        i_btn_right;
	logic        i_btn_left;
	logic        i_btn_up;
	logic        i_btn_down;
	logic        i_psel;
	logic        i_penable;
	logic        i_pwrite;
	logic [7:0]  i_paddr;
	logic [31:0] i_pwdata;
	logic [31:0] o_prdata;
	logic        o_pready;
	logic        o_pslverr;
	logic [7:0]  o_r;
	logic [7:0]  o_g;
	logic [7:0]  o_b;

	integer      seed;
	int          errors;
	int          checks;
	bit          loaded; // watchdog starts once the budget is known
	longint      budget_ns;

	// one entry per pattern line
	logic [7:0]  cmd_q [$];
	logic [31:0] arg_a_q [$];
	logic [31:0] arg_b_q [$];
	logic [31:0] arg_c_q [$];

	snake_top dut (
		.i_clk_74M (i_clk_74M), .i_reset (i_reset), .i_hcnt (i_hcnt), .i_vcnt (i_vcnt),
		.i_btn_right (i_btn_right), .i_btn_left (i_btn_left),
		.i_btn_up (i_btn_up), .i_btn_down (i_btn_down),
		.i_psel (i_psel), .i_penable (i_penable), .i_pwrite (i_pwrite),
		.i_paddr (i_paddr), .i_pwdata (i_pwdata),
		.o_prdata (o_prdata), .o_pready (o_pready), .o_pslverr (o_pslverr),
		.o_r (o_r), .o_g (o_g), .o_b (o_b)
	);

	initial begin
		i_clk_74M = 1'b0;
		forever #(clk_half_ns) i_clk_74M = ~i_clk_74M;
	end

	initial begin
		wait (loaded);
		#(budget_ns);
		$display("watchdog expired after %0d ns, the test did not finish", budget_ns);
		$display("Something failed");
		$finish;
	end

	//////////////////////////////
	// apple sequence model
	//////////////////////////////
	function automatic logic [15:0] lfsr_advance(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // taps 16 14 13 11
	endfunction

	function automatic int field_to_cell(input logic [3:0] v);
		return (v <= 4'd12) ? int'(v) + 1 : int'(v) - 12;
	endfunction

	//////////////////////////////
	// bus and pin drivers
	//////////////////////////////
	task automatic apb_transfer(input logic wr, input logic [7:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		i_psel = 1'b1; // setup phase
		i_penable = 1'b0;
		i_pwrite = wr;
		i_paddr = addr;
		i_pwdata = wdata;
		@(posedge i_clk_74M);
		#1;
		i_penable = 1'b1; // access phase
		#2;
		rdata = o_prdata;
		err = o_pslverr;
		checks++;
		if (o_pready !== 1'b1) begin
			errors++;
			$display("** Error at %0d ns: o_pready expected 1 got %b", $time, o_pready);
		end
		@(posedge i_clk_74M);
		#1;
		i_psel = 1'b0;
		i_penable = 1'b0;
		i_pwrite = 1'b0;
	endtask

	// data is the write value or the expected read value
	task automatic register_check(input logic wr, input logic [7:0] addr,
		input logic [31:0] data, input logic exp_err);
		logic [31:0] rdata;
		logic        perr;
		apb_transfer(wr, addr, data, rdata, perr);
		if (!wr) begin
			checks++;
			if (rdata !== data) begin
				errors++;
				$display("** Error at %0d ns: o_prdata at 0x%h expected %h got %h",
					$time, addr, data, rdata);
			end
		end
		checks++;
		if (perr !== exp_err) begin
			errors++;
			$display("** Error at %0d ns: o_pslverr at 0x%h expected %b got %b",
				$time, addr, exp_err, perr);
		end
	endtask

	task automatic press_button(input int which);
		case (which)
			0: i_btn_right = 1'b1;
			1: i_btn_left = 1'b1;
			2: i_btn_up = 1'b1;
			default: i_btn_down = 1'b1;
		endcase
		@(posedge i_clk_74M);
		#1;
		i_btn_right = 1'b0;
		i_btn_left = 1'b0;
		i_btn_up = 1'b0;
		i_btn_down = 1'b0;
	endtask

	// k moves fit before the next step is due
	task automatic run_moves(input int moves, input int period);
		logic [31:0] rd;
		logic        er;
		apb_transfer(1'b1, 8'h00, 32'd1, rd, er);
		repeat (moves * period + period / 2) @(posedge i_clk_74M);
		#1;
		apb_transfer(1'b1, 8'h00, 32'd0, rd, er); // frozen for the checks
	endtask

	task automatic check_pixel(input int cx, input int cy, input logic [23:0] exp_rgb);
		logic [23:0] got;
		i_hcnt = 12'(cx * 32 + ($random(seed) & 31)); // anywhere in the cell
		i_vcnt = 12'(cy * 32 + ($random(seed) & 31));
		@(posedge i_clk_74M);
		#1;
		got = {o_r, o_g, o_b};
		checks++;
		if (got !== exp_rgb) begin
			errors++;
			$display("** Error at %0d ns: {o_r,o_g,o_b} at cell (%0d,%0d) expected %h got %h",
				$time, cx, cy, exp_rgb, got);
		end
	endtask

	task automatic idle_sweep();
		repeat (2) begin
			i_hcnt = 12'($random(seed));
			i_vcnt = 12'($random(seed));
			@(posedge i_clk_74M);
			#1;
		end
	endtask

	task automatic load_patterns();
		int          fd;
		int          n;
		string       line;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		longint      budget_clks;
		budget_clks = 0;
		fd = $fopen("snake_patterns.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open snake_patterns.txt, no commands were run");
		end else begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n < 2 || line.getc(0) == "#") continue;
				a = '0;
				b = '0;
				c = '0;
				n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c);
				cmd_q.push_back(line.getc(0));
				arg_a_q.push_back(a);
				arg_b_q.push_back(b);
				arg_c_q.push_back(c);
				if (line.getc(0) == "M") budget_clks += a * b + b / 2;
				budget_clks += cmd_clks;
			end
			$fclose(fd);
		end
		budget_ns = (budget_clks + reset_cycles + slack_clks) * 2 * clk_half_ns;
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////
	initial begin
		logic [15:0] lfsr_model;
		seed = seed_start;
		errors = 0;
		checks = 0;
		loaded = 1'b0;
		i_reset = 1'b1;
		i_hcnt = '0;
		i_vcnt = '0;
		i_btn_right = 1'b0;
		i_btn_left = 1'b0;
		i_btn_up = 1'b0;
		i_btn_down = 1'b0;
		i_psel = 1'b0;
		i_penable = 1'b0;
		i_pwrite = 1'b0;
		i_paddr = '0;
		i_pwdata = '0;
		load_patterns();
		lfsr_model = 16'hACE1;
		for (int m = 1; m <= 4; m++) begin
			lfsr_model = lfsr_advance(lfsr_model);
			$display("note: apple after meal %0d expected at cell (%0d,%0d)", m,
				field_to_cell(lfsr_model[3:0]), field_to_cell(lfsr_model[7:4]));
		end
		loaded = 1'b1;
		repeat (reset_cycles) @(posedge i_clk_74M);
		#1;
		i_reset = 1'b0;
		register_check(1'b0, 8'h00, 32'h0000_0000, 1'b0); // run is off after reset
		register_check(1'b0, 8'h08, 32'h0000_0000, 1'b0); // no score yet
		foreach (cmd_q[i]) begin
			case (cmd_q[i])
				"W": register_check(1'b1, arg_a_q[i][7:0], arg_b_q[i], arg_c_q[i][0]);
				"R": register_check(1'b0, arg_a_q[i][7:0], arg_b_q[i], arg_c_q[i][0]);
				"B": press_button(int'(arg_a_q[i]));
				"M": run_moves(int'(arg_a_q[i]), int'(arg_b_q[i]));
				"P": check_pixel(int'(arg_a_q[i]), int'(arg_b_q[i]), arg_c_q[i][23:0]);
				default: begin
					errors++;
					$display("pattern entry %0d has an unknown command", i);
				end
			endcase
			idle_sweep();
		end
		$display("%0d checks done, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// ==== snake_patterns.txt ====
# W addr wdata err | R addr rdata err | B button (0 right, 1 left, 2 up, 3 down)
# M moves period | P cell_x cell_y rgb, all numbers hex
# register reset values, error responses, interval floor
R 04 017d7840 0
R 0c 00000100 0
W 08 00000005 1
R 10 00000000 1
W 04 00000005 0
R 04 00000018 0
# move right to the edge, turn back ignored, wrap to 1
M 0b 18
P 0d 0c 20e020
B 1
M 01 18
P 01 0c 20e020
# first meal at (10,10), next apple at (4,13)
B 2
M 02 18
B 0
M 09 18
R 08 00000001 0
P 09 0a 109010
P 04 0d f01010
# meals two to four, apples (8,9) (3,1) then (2,2)
B 3
M 03 18
B 1
M 06 18
B 2
M 04 18
B 0
M 04 18
B 2
M 08 18
B 1
M 05 18
R 0c 00000500 0
P 08 01 000000
P 00 00 b04020
P 07 0e b04020
P 0f 03 000000
# closed loop into its own body
B 3
M 01 18
B 0
M 01 18
B 2
M 01 18
R 0c 00000501 0
P 04 01 e020e0
M 01 18
R 0c 00000500 0

// ==== sim.f ====
snake_game_pkg.sv
snake_apb_pkg.sv
snake_state_if.sv
snake_apb_regs.sv
snake_motion.sv
snake_bite_check.sv
apple_placer.sv
snake_renderer.sv
snake_top.sv
tb_snake.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the snake testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_snake -f sim.f -o tb_snake_sim
./obj_dir/tb_snake_sim | tee sim.log
if grep -qx "Everything OK" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi
